/* hw/lsu_pkg.sv */
/*
 * Load/store unit shared types
 * Width typedefs and access size codes used across the pipeline stages
 */

package lsu_pkg;

   //**************************************************************************
   // Widths with a meaning
   //**************************************************************************
   typedef logic [31:0]        data_t;      // Operand, store data, load result
   typedef logic [31:0]        addr_t;      // Byte address
   typedef logic signed [11:0] offset_t;    // Immediate address offset
   typedef logic [3:0]         byte_en_t;   // One bit per byte lane
   typedef logic [1:0]         lane_t;      // Byte offset within a word

   //**************************************************************************
   // Access size codes
   //**************************************************************************
   typedef logic [1:0] lsu_size_t;

   localparam lsu_size_t SIZE_BYTE = 2'd0;
   localparam lsu_size_t SIZE_HALF = 2'd1;
   localparam lsu_size_t SIZE_WORD = 2'd2;

endpackage

/* hw/lsu_dccm.sv */
/*
 * DCCM array
 * Word-wide memory with byte write enables and a registered read port
 */

`timescale 1ns/1ps

module lsu_dccm #(
   parameter int DCCM_INDEX_BITS = 8
) (
   input  logic                       clk,
   input  logic                       wr_en,
   input  logic                       rd_en,
   input  logic [DCCM_INDEX_BITS-1:0] index,
   input  lsu_pkg::byte_en_t          byte_en,
   input  lsu_pkg::data_t             wdata,
   output lsu_pkg::data_t             rdata
);

   lsu_pkg::data_t mem [2**DCCM_INDEX_BITS];   // Contents undefined until written

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) mem[index][8*i +: 8] <= wdata[8*i +: 8];
         end
      end
      if (rd_en) rdata <= mem[index];   // Holds last read otherwise
   end

endmodule

/* hw/lsu_decode.sv */
/*
 * Decode stage
 * Effective address, DCCM region and alignment checks, dc1 packet register
 */

`timescale 1ns/1ps

module lsu_decode #(
   parameter lsu_pkg::addr_t DCCM_BASE       = 32'hF004_0000,
   parameter int             DCCM_INDEX_BITS = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  logic               req_load,
   input  logic               req_store,
   input  logic               req_unsigned,
   input  lsu_pkg::lsu_size_t req_size,
   input  lsu_pkg::data_t     rs1,
   input  lsu_pkg::data_t     rs2,
   input  lsu_pkg::offset_t   offset,
   output logic               dc1_valid,
   output logic               dc1_load,
   output logic               dc1_unsigned,
   output logic               dc1_misaligned,
   output logic               dc1_access_fault,
   output lsu_pkg::lsu_size_t dc1_size,
   output lsu_pkg::addr_t     dc1_addr,
   output lsu_pkg::data_t     dc1_wdata
);

   localparam int REGION_LSB = DCCM_INDEX_BITS + 2;   // First bit above the word index

   lsu_pkg::addr_t eff_addr;
   logic           req_ok;
   logic           in_dccm;
   logic           misaligned;

   assign req_ok   = req_valid & (req_load ^ req_store);   // Exactly one of load/store
   assign eff_addr = rs1 + {{20{offset[11]}}, offset};
   assign in_dccm  = (eff_addr[31:REGION_LSB] == DCCM_BASE[31:REGION_LSB]);

   assign misaligned = ((req_size == lsu_pkg::SIZE_HALF) & eff_addr[0]) |
                       ((req_size == lsu_pkg::SIZE_WORD) & (|eff_addr[1:0]));

   //**************************************************************************
   // dc1 packet register
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dc1_valid <= 1'b0;
      end else begin
         dc1_valid <= req_ok;
      end
   end

   always_ff @(posedge clk) begin
      if (req_ok) begin
         dc1_load         <= req_load;
         dc1_unsigned     <= req_unsigned;
         dc1_misaligned   <= misaligned;
         dc1_access_fault <= ~in_dccm;   // Outside the DCCM window
         dc1_size         <= req_size;
         dc1_addr         <= eff_addr;
         dc1_wdata        <= rs2;
      end
   end

endmodule

/* hw/lsu_execute.sv */
/*
 * Execute stage
 * Flush kill, store byte lanes, DCCM write/read and the dc2 register
 */

`timescale 1ns/1ps

module lsu_execute #(
   parameter int DCCM_INDEX_BITS = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               flush_dc1,
   input  logic               dc1_valid,
   input  logic               dc1_load,
   input  logic               dc1_unsigned,
   input  logic               dc1_misaligned,
   input  logic               dc1_access_fault,
   input  lsu_pkg::lsu_size_t dc1_size,
   input  lsu_pkg::addr_t     dc1_addr,
   input  lsu_pkg::data_t     dc1_wdata,
   output logic               dc2_load_valid,
   output logic               dc2_unsigned,
   output logic               dc2_error,
   output logic               dc2_misaligned,
   output lsu_pkg::lsu_size_t dc2_size,
   output lsu_pkg::lane_t     dc2_lane,
   output lsu_pkg::addr_t     dc2_addr,
   output lsu_pkg::data_t     dc2_rdata
);

   logic                       live;
   logic                       fault;
   logic                       wr_en;
   logic                       rd_en;
   lsu_pkg::lane_t             lane;
   lsu_pkg::byte_en_t          byte_en;
   lsu_pkg::data_t             wdata;
   logic [DCCM_INDEX_BITS-1:0] index;

   assign live  = dc1_valid & ~flush_dc1;               // Flush kills the dc1 packet
   assign fault = dc1_misaligned | dc1_access_fault;
   assign wr_en = live & ~dc1_load & ~fault;            // Faulting stores never write
   assign rd_en = live & dc1_load & ~fault;

   assign lane  = dc1_addr[1:0];
   assign index = dc1_addr[DCCM_INDEX_BITS+1:2];
   assign wdata = dc1_wdata << {lane, 3'b000};          // Move store data to its lane

   always_comb begin
      case (dc1_size)
         lsu_pkg::SIZE_BYTE: byte_en = 4'b0001 << lane;
         lsu_pkg::SIZE_HALF: byte_en = 4'b0011 << lane;
         default:            byte_en = 4'b1111;
      endcase
   end

   lsu_dccm #(
      .DCCM_INDEX_BITS (DCCM_INDEX_BITS)
   ) u_dccm (
      .clk, .wr_en, .rd_en, .index, .byte_en, .wdata,
      .rdata (dc2_rdata)
   );

   //**************************************************************************
   // dc2 register, aligned with the DCCM read data
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dc2_load_valid <= 1'b0;
         dc2_error      <= 1'b0;
      end else begin
         dc2_load_valid <= rd_en;
         dc2_error      <= live & fault;
      end
   end

   always_ff @(posedge clk) begin
      dc2_unsigned   <= dc1_unsigned;
      dc2_misaligned <= dc1_misaligned;
      dc2_size       <= dc1_size;
      dc2_lane       <= lane;
      dc2_addr       <= dc1_addr;
   end

endmodule

/* hw/lsu_result.sv */
/*
 * Result stage
 * Load alignment and extension, error cause selection, output register
 */

`timescale 1ns/1ps

module lsu_result (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               dc2_load_valid,
   input  logic               dc2_unsigned,
   input  logic               dc2_error,
   input  logic               dc2_misaligned,
   input  lsu_pkg::lsu_size_t dc2_size,
   input  lsu_pkg::lane_t     dc2_lane,
   input  lsu_pkg::addr_t     dc2_addr,
   input  lsu_pkg::data_t     dc2_rdata,
   output logic               load_valid,
   output logic               error_valid,
   output logic               error_misaligned,
   output logic               error_access,
   output lsu_pkg::data_t     load_data,
   output lsu_pkg::addr_t     error_addr
);

   lsu_pkg::data_t shifted;
   lsu_pkg::data_t aligned;
   logic           sign_ok;

   assign shifted = dc2_rdata >> {dc2_lane, 3'b000};   // Addressed byte to bit 0
   assign sign_ok = ~dc2_unsigned;

   always_comb begin
      case (dc2_size)
         lsu_pkg::SIZE_BYTE: aligned = {{24{sign_ok & shifted[7]}}, shifted[7:0]};
         lsu_pkg::SIZE_HALF: aligned = {{16{sign_ok & shifted[15]}}, shifted[15:0]};
         default:            aligned = shifted;
      endcase
   end

   //**************************************************************************
   // Output register
   //**************************************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_valid       <= 1'b0;
         error_valid      <= 1'b0;
         error_misaligned <= 1'b0;
         error_access     <= 1'b0;
      end else begin
         load_valid       <= dc2_load_valid;
         error_valid      <= dc2_error;
         error_misaligned <= dc2_error & dc2_misaligned;
         error_access     <= dc2_error & ~dc2_misaligned;   // Misaligned wins
      end
   end

   always_ff @(posedge clk) begin
      if (dc2_load_valid) load_data <= aligned;
      if (dc2_error) error_addr <= dc2_addr;
   end

endmodule

/* hw/lsu_top.sv */
/*
 * Load/store unit top level
 * Decode, execute and result stages around a local data memory (DCCM)
 */

`timescale 1ns/1ps

module lsu_top #(
   parameter lsu_pkg::addr_t DCCM_BASE       = 32'hF004_0000,
   parameter int             DCCM_INDEX_BITS = 8
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  logic               req_load,
   input  logic               req_store,
   input  logic               req_unsigned,
   input  lsu_pkg::lsu_size_t req_size,
   input  lsu_pkg::data_t     rs1,
   input  lsu_pkg::data_t     rs2,
   input  lsu_pkg::offset_t   offset,
   input  logic               flush_dc1,
   output logic               load_valid,
   output lsu_pkg::data_t     load_data,
   output logic               error_valid,
   output logic               error_misaligned,
   output logic               error_access,
   output lsu_pkg::addr_t     error_addr
);

   // dc1 packet
   logic               dc1_valid;
   logic               dc1_load;
   logic               dc1_unsigned;
   logic               dc1_misaligned;
   logic               dc1_access_fault;
   lsu_pkg::lsu_size_t dc1_size;
   lsu_pkg::addr_t     dc1_addr;
   lsu_pkg::data_t     dc1_wdata;

   // dc2 packet
   logic               dc2_load_valid;
   logic               dc2_unsigned;
   logic               dc2_error;
   logic               dc2_misaligned;
   lsu_pkg::lsu_size_t dc2_size;
   lsu_pkg::lane_t     dc2_lane;
   lsu_pkg::addr_t     dc2_addr;
   lsu_pkg::data_t     dc2_rdata;

   lsu_decode #(
      .DCCM_BASE       (DCCM_BASE),
      .DCCM_INDEX_BITS (DCCM_INDEX_BITS)
   ) u_decode (
      .clk, .rst_n,
      .req_valid, .req_load, .req_store, .req_unsigned, .req_size,
      .rs1, .rs2, .offset,
      .dc1_valid, .dc1_load, .dc1_unsigned, .dc1_misaligned, .dc1_access_fault,
      .dc1_size, .dc1_addr, .dc1_wdata
   );

   lsu_execute #(
      .DCCM_INDEX_BITS (DCCM_INDEX_BITS)
   ) u_execute (
      .clk, .rst_n, .flush_dc1,
      .dc1_valid, .dc1_load, .dc1_unsigned, .dc1_misaligned, .dc1_access_fault,
      .dc1_size, .dc1_addr, .dc1_wdata,
      .dc2_load_valid, .dc2_unsigned, .dc2_error, .dc2_misaligned,
      .dc2_size, .dc2_lane, .dc2_addr, .dc2_rdata
   );

   lsu_result u_result (
      .clk, .rst_n,
      .dc2_load_valid, .dc2_unsigned, .dc2_error, .dc2_misaligned,
      .dc2_size, .dc2_lane, .dc2_addr, .dc2_rdata,
      .load_valid, .error_valid, .error_misaligned, .error_access,
      .load_data, .error_addr
   );

endmodule

/* verif/lsu_properties.sv */
/*
 * Load/store unit output properties
 * Result and error outputs stay exclusive and quiet during reset
 */

`timescale 1ns/1ps

module lsu_properties (
   input logic clk,
   input logic rst_n,
   input logic load_valid,
   input logic error_valid,
   input logic error_misaligned,
   input logic error_access
);

   // One result per cycle at most
   one_output: assert property (@(posedge clk) disable iff (!rst_n)
      !(load_valid && error_valid))
      else $error("load_valid and error_valid high together");

   cause_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (error_misaligned || error_access) |-> error_valid)
      else $error("Error cause set without error_valid");

   quiet_in_reset: assert property (@(posedge clk)
      !rst_n |-> (!load_valid && !error_valid))
      else $error("Output valid high during reset");

endmodule

bind lsu_top lsu_properties u_properties (
   .clk, .rst_n, .load_valid, .error_valid, .error_misaligned, .error_access
);

/* verif/lsu_tb.sv */
/*
 * Load/store unit testbench
 * Directed tests checked against a byte-wide reference model of the DCCM
 */

`timescale 1ns/1ps

module lsu_tb;

   localparam logic [31:0] BASE       = 32'hF004_0000;
   localparam int          INDEX_BITS = 8;
   localparam int          MEM_BYTES  = 4 << INDEX_BITS;
   localparam int          DRAIN_MAX  = 16;

   typedef struct packed {
      int          due;        // Cycle in which the output is visible
      logic        is_load;
      logic [31:0] data;
      logic        mis;
      logic        acc;
      logic [31:0] addr;
   } expect_t;

   logic               clk;
   logic               rst_n;
   logic               req_valid;
   logic               req_load;
   logic               req_store;
   logic               req_unsigned;
   lsu_pkg::lsu_size_t req_size;
   lsu_pkg::data_t     rs1;
   lsu_pkg::data_t     rs2;
   lsu_pkg::offset_t   offset;
   logic               flush_dc1;
   logic               load_valid;
   lsu_pkg::data_t     load_data;
   logic               error_valid;
   logic               error_misaligned;
   logic               error_access;
   lsu_pkg::addr_t     error_addr;

   logic [7:0] ref_mem [MEM_BYTES];
   expect_t    exp_q [$];
   expect_t    head;
   int         cyc        = 0;
   int         errors     = 0;
   int         checks     = 0;
   int         err_mark   = 0;
   int         tests      = 0;
   int         seed       = 23846;
   logic       flush_next = 1'b0;   // Flush for the packet now entering dc1

   lsu_top #(
      .DCCM_BASE       (BASE),
      .DCCM_INDEX_BITS (INDEX_BITS)
   ) DUT (
      .clk, .rst_n, .req_valid, .req_load, .req_store, .req_unsigned, .req_size,
      .rs1, .rs2, .offset, .flush_dc1,
      .load_valid, .load_data, .error_valid, .error_misaligned, .error_access, .error_addr
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   //***************************************************************************
   // Reference model
   //***************************************************************************
   function automatic logic [31:0] sext12(input logic [11:0] off);
      return {{20{off[11]}}, off};
   endfunction

   function automatic logic [31:0] model_load(input logic [31:0] ea,
                                              input lsu_pkg::lsu_size_t size, input logic uns);
      int          b;
      logic [15:0] half;
      b = ea[INDEX_BITS+1:0];
      case (size)
         lsu_pkg::SIZE_BYTE: return uns ? {24'd0, ref_mem[b]} : {{24{ref_mem[b][7]}}, ref_mem[b]};
         lsu_pkg::SIZE_HALF: begin
            half = {ref_mem[b+1], ref_mem[b]};
            return uns ? {16'd0, half} : {{16{half[15]}}, half};
         end
         default: return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
      endcase
   endfunction

   task automatic model_store(input logic [31:0] ea, input lsu_pkg::lsu_size_t size,
                              input logic [31:0] data);
      int b;
      int n;
      b = ea[INDEX_BITS+1:0];
      n = (size == lsu_pkg::SIZE_BYTE) ? 1 : (size == lsu_pkg::SIZE_HALF) ? 2 : 4;
      for (int i = 0; i < n; i++) ref_mem[b+i] = data[8*i +: 8];
   endtask

   //***************************************************************************
   // Drive and check
   //***************************************************************************
   task automatic check_value(input string name, input logic [31:0] expv, input logic [31:0] got);
      checks++;
      assert (got === expv) else begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, expv, got);
         errors++;
      end
   endtask

   task automatic issue_req(input logic ld, input lsu_pkg::lsu_size_t size, input logic uns,
                            input logic [31:0] base, input logic [31:0] wdata,
                            input logic [11:0] off, input logic flush);
      logic [31:0] ea;
      logic        mis;
      logic        acc;
      expect_t     e;
      ea  = base + sext12(off);
      mis = (size == lsu_pkg::SIZE_HALF && ea[0]) || (size == lsu_pkg::SIZE_WORD && ea[1:0] != 0);
      acc = (ea >> (INDEX_BITS + 2)) != (BASE >> (INDEX_BITS + 2));
      @(posedge clk);
      req_valid    <= 1'b1;
      req_load     <= ld;
      req_store    <= !ld;
      req_size     <= size;
      req_unsigned <= uns;
      rs1          <= base;
      rs2          <= wdata;
      offset       <= off;
      flush_dc1    <= flush_next;
      flush_next    = flush;
      e             = '0;
      e.due         = cyc + 4;   // Sampled next edge, visible two edges later
      e.addr        = ea;
      if (flush) return;
      if (mis || acc) begin
         e.mis = mis;
         e.acc = acc && !mis;   // Misaligned takes priority
         exp_q.push_back(e);
      end else if (ld) begin
         e.is_load = 1'b1;
         e.data    = model_load(ea, size, uns);
         exp_q.push_back(e);
      end else begin
         model_store(ea, size, wdata);
      end
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      req_valid <= 1'b0;
      flush_dc1 <= flush_next;
      flush_next = 1'b0;
   endtask

   task automatic drain_pipe();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_MAX) begin
         idle_cycle();
         n++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d expected outputs never appeared", exp_q.size());
         errors++;
         exp_q.delete();
      end
      repeat (2) idle_cycle();   // No stray outputs after the last one
   endtask

   task automatic finish_test(input string name);
      drain_pipe();
      $display("%s done, %0d errors", name, errors - err_mark);
      err_mark = errors;
      tests++;
   endtask

   always @(negedge clk) begin
      if (rst_n) begin
         if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            head = exp_q.pop_front();
            check_value("load_valid", head.is_load, load_valid);
            check_value("error_valid", !head.is_load, error_valid);
            if (head.is_load) begin
               check_value("load_data", head.data, load_data);
            end else begin
               check_value("error_misaligned", head.mis, error_misaligned);
               check_value("error_access", head.acc, error_access);
               check_value("error_addr", head.addr, error_addr);
            end
         end else begin
            check_value("load_valid", 1'b0, load_valid);
            check_value("error_valid", 1'b0, error_valid);
         end
      end
   end

   //***************************************************************************
   // Tests
   //***************************************************************************
   task automatic word_round_trip();
      for (int i = 0; i < (1 << INDEX_BITS); i++)
         issue_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, BASE + 4 * i, $random(seed), 12'd0, 1'b0);
      for (int i = 0; i < (1 << INDEX_BITS); i++)
         issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 4 * i, 32'd0, 12'd0, 1'b0);
      finish_test("word_round_trip");
   endtask

   task automatic sub_word_access();
      for (int l = 0; l < 4; l++)   // Offset -16 reaches word 0x30
         issue_req(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, BASE + 32'h40,
                   32'hDEAD_BE00 | (8'h7C + 8'h11 * l), 12'hFF0 + 12'(l), 1'b0);
      issue_req(1'b0, lsu_pkg::SIZE_HALF, 1'b0, BASE + 32'h34, 32'h1234_9A5B, 12'd2, 1'b0);
      for (int l = 0; l < 4; l++) begin
         issue_req(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, BASE + 32'h30, 32'd0, 12'(l), 1'b0);
         issue_req(1'b1, lsu_pkg::SIZE_BYTE, 1'b1, BASE + 32'h30, 32'd0, 12'(l), 1'b0);
      end
      for (int l = 0; l < 4; l += 2) begin
         issue_req(1'b1, lsu_pkg::SIZE_HALF, 1'b0, BASE + 32'h34, 32'd0, 12'(l), 1'b0);
         issue_req(1'b1, lsu_pkg::SIZE_HALF, 1'b1, BASE + 32'h34, 32'd0, 12'(l), 1'b0);
      end
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h30, 32'd0, 12'd0, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h34, 32'd0, 12'd0, 1'b0);
      finish_test("sub_word_access");
   endtask

   task automatic misaligned_fault();
      issue_req(1'b0, lsu_pkg::SIZE_HALF, 1'b0, BASE + 32'h41, 32'hFFFF_FFFF, 12'd0, 1'b0);
      issue_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h40, 32'hFFFF_FFFF, 12'd2, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h43, 32'd0, 12'd0, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_HALF, 1'b1, BASE + 32'h48, 32'd0, 12'hFFF, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h40, 32'd0, 12'd0, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h44, 32'd0, 12'd0, 1'b0);
      finish_test("misaligned_fault");
   endtask

   task automatic access_fault();
      issue_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, BASE + MEM_BYTES, 32'hCAFE_F00D, 12'd0, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE, 32'd0, 12'hFFC, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_BYTE, 1'b1, 32'h0000_1000, 32'd0, 12'd0, 1'b0);
      issue_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, BASE + MEM_BYTES, 32'd0, 12'd2, 1'b0);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE, 32'd0, 12'd0, 1'b0);   // Aliased word intact
      finish_test("access_fault");
   endtask

   task automatic flush_kill();
      issue_req(1'b0, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h80, 32'h5555_AAAA, 12'd0, 1'b1);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h80, 32'd0, 12'd0, 1'b1);
      issue_req(1'b0, lsu_pkg::SIZE_HALF, 1'b0, BASE + 32'h81, 32'd0, 12'd0, 1'b1);
      issue_req(1'b1, lsu_pkg::SIZE_WORD, 1'b0, BASE + 32'h80, 32'd0, 12'd0, 1'b0);
      finish_test("flush_kill");
   endtask

   task automatic random_stream();
      logic [31:0]        ea;
      logic [11:0]        off;
      lsu_pkg::lsu_size_t size;
      for (int i = 0; i < 200; i++) begin
         size = $random(seed);
         if (size == 2'd3) size = lsu_pkg::SIZE_WORD;
         ea = BASE + ($random(seed) & (MEM_BYTES - 4));
         if (size == lsu_pkg::SIZE_BYTE) ea[1:0] = $random(seed);
         if (size == lsu_pkg::SIZE_HALF) ea[1] = $random(seed);
         off = $random(seed);
         issue_req($random(seed), size, $random(seed), ea - sext12(off), $random(seed), off, 1'b0);
      end
      finish_test("random_stream");
   endtask

   initial begin
      rst_n        = 1'b0;
      req_valid    = 1'b0;
      req_load     = 1'b0;
      req_store    = 1'b0;
      req_unsigned = 1'b0;
      req_size     = lsu_pkg::SIZE_WORD;
      rs1          = '0;
      rs2          = '0;
      offset       = '0;
      flush_dc1    = 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      word_round_trip();
      sub_word_access();
      misaligned_fault();
      access_fault();
      flush_kill();
      random_stream();
      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* flist.f */
hw/lsu_pkg.sv
hw/lsu_dccm.sv
hw/lsu_decode.sv
hw/lsu_execute.sv
hw/lsu_result.sv
hw/lsu_top.sv
verif/lsu_properties.sv
verif/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - hw/lsu_pkg.sv
  - hw/lsu_dccm.sv
  - hw/lsu_decode.sv
  - hw/lsu_execute.sv
  - hw/lsu_result.sv
  - hw/lsu_top.sv
  - target: test
    files:
      - verif/lsu_properties.sv
      - verif/lsu_tb.sv
